// File: router_settings.svh
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Flit field widths
`define FLIT_KIND_W 3
`define FLIT_DATA_W 12

`define NUM_PORTS 5

`define DROP_CNT_W 8

// Flit kind codes
`define KIND_HEADER 3'd1
`define KIND_BODY   3'd2

`endif

// File: routerPkg.sv
`include "router_settings.svh"

package routerPkg;

  typedef logic [`FLIT_KIND_W-1:0] flitKindT;
  typedef logic [`FLIT_DATA_W-1:0] flitDataT;

  typedef struct packed {
    flitKindT kind;
    flitDataT data;  // Packet length for a header, payload for a body flit
  } flitT;

  typedef logic [$clog2(`NUM_PORTS)-1:0] portIdT;

  localparam portIdT PORT_L = 3'd0;
  localparam portIdT PORT_N = 3'd1;
  localparam portIdT PORT_E = 3'd2;
  localparam portIdT PORT_W = 3'd3;
  localparam portIdT PORT_S = 3'd4;

  typedef struct packed {
    portIdT src;
    flitT   flit;
  } outFlitT;

  typedef enum logic [2:0] {
    IDLE,
    GRANT_L,
    GRANT_N,
    GRANT_E,
    GRANT_W,
    GRANT_S
  } grantStateT;

  function automatic portIdT grantPort(input grantStateT g);
    portIdT p;
    case (g)
      GRANT_N: p = PORT_N;
      GRANT_E: p = PORT_E;
      GRANT_W: p = PORT_W;
      GRANT_S: p = PORT_S;
      default: p = PORT_L;  // IDLE maps to L, callers check for IDLE themselves
    endcase
    return p;
  endfunction

  function automatic grantStateT portGrant(input portIdT p);
    grantStateT g;
    case (p)
      PORT_L:  g = GRANT_L;
      PORT_N:  g = GRANT_N;
      PORT_E:  g = GRANT_E;
      PORT_W:  g = GRANT_W;
      PORT_S:  g = GRANT_S;
      default: g = IDLE;
    endcase
    return g;
  endfunction

endpackage

// File: flitDecoder.sv
`timescale 1ns/1ns
`include "router_settings.svh"

module flitDecoder (
  input  logic             clk,
  input  logic             rst,
  input  logic             inValid,
  input  routerPkg::flitT  inFlit,
  input  logic             transfer,
  output logic             req,
  output logic             lastFlit,
  output logic             strayDrop
);

  logic                inPacket;
  routerPkg::flitDataT budget;  // Flits still owed after the last transferred one

  logic isHeader;
  logic isBody;
  logic member;
  logic shortPacket;

  always_comb
  begin
    isHeader    = inFlit.kind == `KIND_HEADER;
    isBody      = inFlit.kind == `KIND_BODY;
    shortPacket = inFlit.data < 2;  // A zero length is taken as a lone header

    // A header may only open a packet, a body flit may only continue one
    member = (isHeader && !inPacket) || (isBody && inPacket);

    req       = inValid && member;
    strayDrop = inValid && !member;
    lastFlit  = member && ((isHeader && shortPacket) || (isBody && budget == 1));
  end

  // The budget survives a lost grant, so an interrupted packet picks up where it stopped
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPacket <= 1'b0;
      budget   <= '0;
    end
    else if (transfer)
    begin
      if (isHeader)
      begin
        inPacket <= !shortPacket;
        budget   <= shortPacket ? '0 : inFlit.data - 1'b1;
      end
      else
      begin
        inPacket <= budget != 1;  // Packet closes with its final body flit
        budget   <= budget - 1'b1;
      end
    end
  end

endmodule

// File: portArbiter.sv
`timescale 1ns/1ns
`include "router_settings.svh"

module portArbiter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`NUM_PORTS-1:0]   req,
  input  logic [`NUM_PORTS-1:0]   lastFlit,
  input  logic [`NUM_PORTS-1:0]   transfer,
  output routerPkg::grantStateT   grant
);

  routerPkg::grantStateT nextGrant;
  routerPkg::portIdT     curPort;
  routerPkg::portIdT     searchStart;
  logic                  granted;
  logic                  packetDone;
  logic                  holdGrant;

  always_comb
  begin
    granted = grant != routerPkg::IDLE;
    curPort = routerPkg::grantPort(grant);

    // Last flit leaving this cycle means the grant may move on the same edge
    packetDone = transfer[curPort] && lastFlit[curPort];
    holdGrant  = granted && req[curPort] && !packetDone;

    // Ring search begins after the current owner, or at L from IDLE
    if (!granted)
      searchStart = routerPkg::PORT_L;
    else if (curPort == routerPkg::PORT_S)
      searchStart = routerPkg::PORT_L;
    else
      searchStart = curPort + 1'b1;
  end

  always_comb
  begin : ringSearch
    int idx;
    idx       = 0;
    nextGrant = routerPkg::IDLE;
    if (holdGrant)
    begin
      nextGrant = grant;
    end
    else
    begin
      // Walk the ring backwards so the first requester in ring order is written last
      // The owner itself comes last, so a lone requester keeps the output
      for (int k = `NUM_PORTS - 1; k >= 0; k--)
      begin
        idx = (int'(searchStart) + k) % `NUM_PORTS;
        if (req[idx])
          nextGrant = routerPkg::portGrant(routerPkg::portIdT'(idx));
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= routerPkg::IDLE;
    else
      grant <= nextGrant;
  end

endmodule

// File: outputSwitch.sv
`timescale 1ns/1ns
`include "router_settings.svh"

module outputSwitch (
  input  logic                   clk,
  input  logic                   rst,
  input  routerPkg::grantStateT  grant,
  input  routerPkg::flitT        inFlit [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0]  transfer,
  output logic                   outValid,
  output routerPkg::outFlitT     outFlit
);

  routerPkg::portIdT selPort;
  logic              selXfer;

  always_comb
  begin
    selPort = routerPkg::grantPort(grant);
    selXfer = (grant != routerPkg::IDLE) && transfer[selPort];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selXfer;  // Single cycle pulse per forwarded flit
  end

  // Output payload only loads on a forwarded flit
  always_ff @(posedge clk)
  begin
    if (selXfer)
    begin
      outFlit.src  <= selPort;
      outFlit.flit <= inFlit[selPort];
    end
  end

endmodule

// File: routerOutputPort.sv
`timescale 1ns/1ns
`include "router_settings.svh"

module routerOutputPort (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`NUM_PORTS-1:0]   inValid,
  input  routerPkg::flitT         inFlit [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0]   inReady,
  output logic                    outValid,
  output routerPkg::outFlitT      outFlit,
  output logic [`DROP_CNT_W-1:0]  dropCount
);

  routerPkg::grantStateT   grant;
  logic [`NUM_PORTS-1:0]   req;
  logic [`NUM_PORTS-1:0]   lastFlit;
  logic [`NUM_PORTS-1:0]   strayDrop;
  logic [`NUM_PORTS-1:0]   transfer;  // Packet flits only, stray discards are excluded
  logic [`DROP_CNT_W:0]    dropSum;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : gPort
    assign inReady[p]  = (grant == routerPkg::portGrant(routerPkg::portIdT'(p))) || strayDrop[p];
    assign transfer[p] = req[p] && inReady[p];

    flitDecoder uDecoder (
      .clk       (clk),
      .rst       (rst),
      .inValid   (inValid[p]),
      .inFlit    (inFlit[p]),
      .transfer  (transfer[p]),
      .req       (req[p]),
      .lastFlit  (lastFlit[p]),
      .strayDrop (strayDrop[p])
    );
  end

  portArbiter uArbiter (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .lastFlit (lastFlit),
    .transfer (transfer),
    .grant    (grant)
  );

  outputSwitch uSwitch (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .inFlit   (inFlit),
    .transfer (transfer),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  // Several ports can drop a stray flit in the same cycle
  assign dropSum = {1'b0, dropCount} + (`DROP_CNT_W + 1)'($countones(strayDrop));

  always_ff @(posedge clk)
  begin
    if (rst)
      dropCount <= '0;
    else if (dropSum[`DROP_CNT_W])
      dropCount <= '1;  // Saturate rather than wrap
    else
      dropCount <= dropSum[`DROP_CNT_W-1:0];
  end

endmodule

// File: tbRouter.sv
`timescale 1ns/1ns
`include "router_settings.svh"

module tbRouter;

  localparam int DROP_MAX    = (1 << `DROP_CNT_W) - 1;
  localparam int DRAIN_LIMIT = 3000;
  localparam int SAT_PACKETS = 6;

  logic                   clk;
  logic                   rst;
  logic [`NUM_PORTS-1:0]  inValid;
  routerPkg::flitT        inFlit [`NUM_PORTS];
  logic [`NUM_PORTS-1:0]  inReady;
  logic                   outValid;
  routerPkg::outFlitT     outFlit;
  logic [`DROP_CNT_W-1:0] dropCount;

  logic [31:0]           rngState;
  int                    errors;
  int                    checks;
  int                    expDrops;
  routerPkg::flitT       expQ [`NUM_PORTS][$];
  int                    pktLeft [`NUM_PORTS];  // Flits the source still has to offer
  int                    satLeft [`NUM_PORTS];
  logic                  curStray [`NUM_PORTS];
  logic                  gapped [`NUM_PORTS];  // Source idled inside its current packet
  logic [`NUM_PORTS-1:0] accepted;
  logic                  xferPrev;
  logic                  satPhase;
  int                    lastHdrSrc;
  int                    owner;
  int                    owed [`NUM_PORTS];

  routerOutputPort dut0 (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .inReady   (inReady),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .dropCount (dropCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic checkVal(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic checkIdle();
    checkVal("outValid", 32'd0, {31'd0, outValid});
    checkVal("inReady", 32'd0, {27'd0, inReady});
    checkVal("dropCount", 32'd0, {24'd0, dropCount});
  endtask

  task automatic offer(input int p, input routerPkg::flitKindT kind,
                       input routerPkg::flitDataT data);
    inValid[p]     = 1'b1;
    inFlit[p].kind = kind;
    inFlit[p].data = data;
  endtask

  // Mode 0 is random traffic, 1 is saturated with no gaps, 2 only finishes open packets
  task automatic driveCycle(input int mode);
    logic [31:0] r;
    int          len;
    @(posedge clk);
    #1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      r = nextRand();
      if (inValid[p] && !accepted[p])
        continue;  // Flit stays on the bus until it transfers
      inValid[p]  = 1'b0;
      curStray[p] = 1'b0;
      if (pktLeft[p] > 0)
      begin
        if (mode == 0 && r[1:0] == 2'd0)
          gapped[p] = 1'b1;
        else
        begin
          offer(p, `KIND_BODY, r[27:16]);
          pktLeft[p]--;
        end
      end
      else if ((mode == 0 && r[1:0] != 2'd0) || (mode == 1 && satLeft[p] > 0))
      begin
        if (mode == 0 && r[4:2] == 3'd1)
        begin
          offer(p, `KIND_BODY, r[27:16]);  // Body flit with no packet open
          curStray[p] = 1'b1;
        end
        else
        begin
          len = 1 + int'(r[7:5]);
          offer(p, `KIND_HEADER, routerPkg::flitDataT'(len));
          pktLeft[p] = len - 1;
          gapped[p]  = 1'b0;
          if (mode == 1)
            satLeft[p]--;
        end
      end
    end
  endtask

  task automatic monitorCycle();
    int              s;
    routerPkg::flitT expFlit;
    // The output belongs to the transfer sampled one cycle earlier
    checkVal("outValid", {31'd0, xferPrev}, {31'd0, outValid});
    if (outValid)
    begin
      s = int'(outFlit.src);
      if (s >= `NUM_PORTS || expQ[s].size() == 0)
      begin
        errors++;
        $display("Output flit at time %0t from port %0d was never sent by that port",
                 $time, s);
      end
      else
      begin
        expFlit = expQ[s].pop_front();
        checkVal("outFlit.flit", {17'd0, expFlit}, {17'd0, outFlit.flit});
        if (owner >= 0 && !gapped[owner])
          checkVal("outFlit.src", owner, s);
        if (outFlit.flit.kind == `KIND_HEADER)
        begin
          owed[s] = int'(outFlit.flit.data) - 1;
          if (satPhase)
          begin
            checkVal("outFlit.src", (lastHdrSrc + 1) % `NUM_PORTS, s);
            lastHdrSrc = s;
          end
        end
        else if (owed[s] > 0)
          owed[s]--;
        owner = (owed[s] > 0) ? s : -1;
      end
    end
    xferPrev = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      accepted[p] = inValid[p] && inReady[p];
      if (accepted[p] && curStray[p])
        expDrops++;
      else if (accepted[p])
      begin
        expQ[p].push_back(inFlit[p]);
        xferPrev = 1'b1;
      end
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst)
      monitorCycle();
  end

  task automatic waitDrain(input int mode, input string phase);
    int   cycles;
    logic busy;
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < DRAIN_LIMIT)
    begin
      driveCycle(mode);
      cycles++;
      busy = inValid != '0;
      for (int p = 0; p < `NUM_PORTS; p++)
        if (pktLeft[p] > 0 || satLeft[p] > 0 || expQ[p].size() != 0)
          busy = 1'b1;
    end
    if (busy)
    begin
      errors++;
      $display("Timeout after %0d cycles, traffic did not drain in the %s phase",
               cycles, phase);
    end
  endtask

  initial
  begin
    rst        = 1'b1;
    inValid    = '0;
    accepted   = '0;
    rngState   = 32'd2490;
    errors     = 0;
    checks     = 0;
    expDrops   = 0;
    xferPrev   = 1'b0;
    satPhase   = 1'b0;
    lastHdrSrc = 0;
    owner      = -1;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlit[p]   = '0;
      pktLeft[p]  = 0;
      satLeft[p]  = 0;
      curStray[p] = 1'b0;
      gapped[p]   = 1'b0;
      owed[p]     = 0;
    end

    for (int i = 0; i < 7; i++)
    begin
      @(negedge clk);
      checkIdle();
    end
    @(posedge clk);  // Eighth and last clock edge with reset held
    #1;
    rst = 1'b0;
    @(negedge clk);
    checkIdle();

    repeat (800) driveCycle(0);
    waitDrain(2, "random");

    // All five ports start packets on the same cycle and never pause
    satPhase   = 1'b1;
    lastHdrSrc = `NUM_PORTS - 1;
    for (int p = 0; p < `NUM_PORTS; p++)
      satLeft[p] = SAT_PACKETS;
    waitDrain(1, "saturated");
    satPhase = 1'b0;

    repeat (400) driveCycle(0);
    waitDrain(2, "final");

    checkVal("dropCount", (expDrops > DROP_MAX) ? DROP_MAX : expDrops, {24'd0, dropCount});

    $display("checks=%0d errors=%0d strayDrops=%0d", checks, errors, expDrops);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
routerPkg.sv
flitDecoder.sv
portArbiter.sv
outputSwitch.sv
routerOutputPort.sv
tbRouter.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the router testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tbRouter -f verilog.f -o simRouter \
  && ./obj_dir/simRouter | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "TEST OK" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation reported errors"; exit 1; }
